/* design/exec_pipe.sv */
`timescale 1ns/1ps

module exec_pipe
	import isa_pkg::*, pipe_pkg::*;
(
	input  logic       clk,
	input  logic       rst,
	input  exec_op_t   issue_op,
	output writeback_t wb
);

	// One valid bit per stage, the last one is the writeback valid
	logic [EXEC_STAGES-1:0] vld_q;

	// Stage 1 operands
	opcode_t     s1_op;
	regspec_t    s1_rt;
	logic [31:0] s1_a;
	logic [31:0] s1_b;

	// Stage 2 result
	regspec_t    s2_rt;
	logic [31:0] s2_data;
	logic [31:0] alu_res;

	// Stage 3 writeback
	regspec_t    s3_rt;
	logic [31:0] s3_data;

	// ========================================
	// Valid tracking
	// ========================================

	// Only operations that write a register ever reach the writeback
	always_ff @(posedge clk or posedge rst)
	begin
		if (rst)
			vld_q <= '0;
		else
			vld_q <= {vld_q[EXEC_STAGES-2:0], issue_op.valid && (issue_op.Rt != '0)};
	end

	// ========================================
	// Datapath
	// ========================================

	// ALU between stage 1 and stage 2
	always_comb
	begin
		case (s1_op)
			OP_ADD, OP_ADDI: alu_res = s1_a + s1_b;
			OP_SUB:          alu_res = s1_a - s1_b;
			OP_AND:          alu_res = s1_a & s1_b;
			OP_XOR:          alu_res = s1_a ^ s1_b;
			OP_ORI:          alu_res = s1_a | s1_b;
			default:         alu_res = 32'h0;
		endcase
	end

	always_ff @(posedge clk)
	begin
		s1_op   <= issue_op.op;
		s1_rt   <= issue_op.Rt;
		s1_a    <= issue_op.a;
		s1_b    <= issue_op.b;
		s2_rt   <= s1_rt;
		s2_data <= alu_res;
		s3_rt   <= s2_rt;
		s3_data <= s2_data;
	end

	assign wb = '{v: vld_q[EXEC_STAGES-1], Rt: s3_rt, data: s3_data};

endmodule

/* design/instr_decode.sv */
`timescale 1ns/1ps

module instr_decode
	import isa_pkg::*;
(
	input  instr_t      head,
	input  logic        nonempty,
	output decode_bus_t db
);

	// ========================================
	// Format selection
	// ========================================

	// The opcode is read through the register view, it sits in the same
	// bits in the immediate view
	always_comb
	begin
		db       = '0;
		db.v     = nonempty;
		db.op    = OP_NOP;

		case (head.r.opcode)
			// Register format, two sources and a target
			OP_ADD, OP_SUB, OP_AND, OP_XOR:
			begin
				db.op    = head.r.opcode;
				db.Rt    = head.r.Rt;
				db.Ra    = head.r.Ra;
				db.Rb    = head.r.Rb;
				db.hasRa = 1'b1;
				db.hasRb = 1'b1;
				db.hasRt = 1'b1;
				db.rfwr  = 1'b1;
			end

			// Add immediate takes a sign extended immediate
			OP_ADDI:
			begin
				db.op     = OP_ADDI;
				db.Rt     = head.i.Rt;
				db.Ra     = head.i.Ra;
				db.hasRa  = 1'b1;
				db.hasRt  = 1'b1;
				db.rfwr   = 1'b1;
				db.is_imm = 1'b1;
				db.imm    = {{16{head.i.imm[15]}}, head.i.imm};
			end

			// Or immediate takes a zero extended immediate
			OP_ORI:
			begin
				db.op     = OP_ORI;
				db.Rt     = head.i.Rt;
				db.Ra     = head.i.Ra;
				db.hasRa  = 1'b1;
				db.hasRt  = 1'b1;
				db.rfwr   = 1'b1;
				db.is_imm = 1'b1;
				db.imm    = {16'h0000, head.i.imm};
			end

			// NOP and unknown opcodes stay valid with no registers attached,
			// so they issue and leave nothing behind
			default:
			begin
				db.op = OP_NOP;
			end
		endcase
	end

endmodule

/* design/instr_queue.sv */
`timescale 1ns/1ps

module instr_queue
	import isa_pkg::*, pipe_pkg::*;
(
	input  logic   clk,
	input  logic   rst,
	input  logic   in_valid,
	input  instr_t in_instr,
	input  logic   pop,
	output instr_t head,
	output logic   nonempty,
	output logic   credit_return
);

	// Storage for the queued words
	instr_t mem [QUEUE_DEPTH];

	logic [QPTR_W-1:0] wr_ptr;
	logic [QPTR_W-1:0] rd_ptr;
	credit_t           count;

	// ========================================
	// Pointers and occupancy
	// ========================================

	// The sender only pushes while holding a credit, so no full check is made here
	always_ff @(posedge clk or posedge rst)
	begin
		if (rst)
		begin
			wr_ptr <= '0;
			rd_ptr <= '0;
			count  <= '0;
		end
		else
		begin
			if (in_valid)
				wr_ptr <= wr_ptr + 1'b1;
			if (pop)
				rd_ptr <= rd_ptr + 1'b1;
			case ({in_valid, pop})
				2'b10:   count <= count + 1'b1;
				2'b01:   count <= count - 1'b1;
				default: count <= count;
			endcase
		end
	end

	// Word write into the slot under the write pointer
	always_ff @(posedge clk)
	begin
		if (in_valid)
			mem[wr_ptr] <= in_instr;
	end

	// Each pop frees one slot and hands one credit back one cycle later
	always_ff @(posedge clk or posedge rst)
	begin
		if (rst)
			credit_return <= 1'b0;
		else
			credit_return <= pop;
	end

	// The head is visible one cycle after the push
	assign head     = mem[rd_ptr];
	assign nonempty = (count != '0);

endmodule

/* design/isa_pkg.sv */
package isa_pkg;

	// ========================================
	// Register specifiers
	// ========================================

	localparam int NUM_REGS = 64;

	// Register number, r0 always reads as zero
	typedef logic [$clog2(NUM_REGS)-1:0] regspec_t;

	// One bit per architectural register
	typedef logic [NUM_REGS-1:0] regs_bitmap_t;

	// ========================================
	// Opcodes and instruction formats
	// ========================================

	// Four bit opcode, values not listed here decode as a NOP
	typedef enum logic [3:0] {
		OP_NOP  = 4'h0,
		OP_ADD  = 4'h1,
		OP_SUB  = 4'h2,
		OP_AND  = 4'h3,
		OP_XOR  = 4'h4,
		OP_ADDI = 4'h5,
		OP_ORI  = 4'h6
	} opcode_t;

	// Register format with two source registers
	typedef struct packed {
		opcode_t     opcode;
		regspec_t    Rt;
		regspec_t    Ra;
		regspec_t    Rb;
		logic [9:0]  unused;
	} rfmt_t;

	// Immediate format, the immediate takes the place of Rb
	typedef struct packed {
		opcode_t     opcode;
		regspec_t    Rt;
		regspec_t    Ra;
		logic [15:0] imm;
	} ifmt_t;

	// The opcode occupies the top nibble in both views
	typedef union packed {
		rfmt_t r;
		ifmt_t i;
	} instr_t;

	// ========================================
	// Decode bus
	// ========================================

	typedef struct packed {
		logic        v;
		opcode_t     op;
		regspec_t    Rt;
		regspec_t    Ra;
		regspec_t    Rb;
		logic        hasRa;
		logic        hasRb;
		logic        hasRt;
		logic        rfwr;
		logic        is_imm;
		logic [31:0] imm;
	} decode_bus_t;

endpackage

/* design/issue_ctrl.sv */
`timescale 1ns/1ps

module issue_ctrl
	import isa_pkg::*, pipe_pkg::*;
(
	input  logic        clk,
	input  logic        rst,
	input  decode_bus_t db,
	input  logic        can_issue,
	input  logic [31:0] rd_a,
	input  logic [31:0] rd_b,
	output logic        will_issue,
	output logic        pop,
	output exec_op_t    issue_op
);

	// ========================================
	// Issue decision
	// ========================================

	// The head leaves the queue in the same cycle it issues
	assign will_issue = db.v && can_issue;
	assign pop        = will_issue;

	// ========================================
	// Operand launch
	// ========================================

	// Operands come straight from the register file, there is no bypass
	always_comb
	begin
		issue_op       = '0;
		issue_op.valid = will_issue;
		issue_op.op    = db.op;

		// Rt stays zero for instructions that write nothing
		if (db.hasRt && db.rfwr)
			issue_op.Rt = db.Rt;

		if (db.hasRa)
			issue_op.a = rd_a;

		// Immediate format replaces the second read with the extended immediate
		if (db.is_imm)
			issue_op.b = db.imm;
		else if (db.hasRb)
			issue_op.b = rd_b;
	end

endmodule

/* design/issue_stage.sv */
`timescale 1ns/1ps

module issue_stage
	import isa_pkg::*, pipe_pkg::*;
(
	input  logic       clk,
	input  logic       rst,
	input  logic       in_valid,
	input  instr_t     in_instr,
	output logic       credit_return,
	output writeback_t wb
);

	// Queue head and its decode
	instr_t      head;
	logic        nonempty;
	decode_bus_t db;

	// Issue handshake between scoreboard and controller
	logic        can_issue;
	logic        will_issue;
	logic        pop;

	// Register read data and the launched operation
	logic [31:0] rd_a;
	logic [31:0] rd_b;
	exec_op_t    issue_op;

	// ========================================
	// Front end
	// ========================================

	instr_queue u_queue (
		.clk           (clk),
		.rst           (rst),
		.in_valid      (in_valid),
		.in_instr      (in_instr),
		.pop           (pop),
		.head          (head),
		.nonempty      (nonempty),
		.credit_return (credit_return)
	);

	instr_decode u_decode (
		.head     (head),
		.nonempty (nonempty),
		.db       (db)
	);

	// ========================================
	// Hazard check and operand read
	// ========================================

	reg_scoreboard u_scoreboard (
		.clk        (clk),
		.rst        (rst),
		.db         (db),
		.wb         (wb),
		.will_issue (will_issue),
		.can_issue  (can_issue)
	);

	reg_file u_reg_file (
		.clk  (clk),
		.rst  (rst),
		.ra   (db.Ra),
		.rb   (db.Rb),
		.rd_a (rd_a),
		.rd_b (rd_b),
		.wb   (wb)
	);

	issue_ctrl u_ctrl (
		.clk        (clk),
		.rst        (rst),
		.db         (db),
		.can_issue  (can_issue),
		.rd_a       (rd_a),
		.rd_b       (rd_b),
		.will_issue (will_issue),
		.pop        (pop),
		.issue_op   (issue_op)
	);

	// ========================================
	// Execute
	// ========================================

	exec_pipe u_exec (
		.clk      (clk),
		.rst      (rst),
		.issue_op (issue_op),
		.wb       (wb)
	);

endmodule

/* design/pipe_pkg.sv */
package pipe_pkg;

	import isa_pkg::*;

	// ========================================
	// Depths
	// ========================================

	// Queue entries, which is also the credit count the sender starts with
	localparam int QUEUE_DEPTH = 4;

	// Pointer width into the instruction queue
	localparam int QPTR_W = $clog2(QUEUE_DEPTH);

	// Cycles from issue to writeback
	localparam int EXEC_STAGES = 3;

	// Wide enough to hold every value from zero up to QUEUE_DEPTH
	typedef logic [$clog2(QUEUE_DEPTH+1)-1:0] credit_t;

	// ========================================
	// Execute and writeback
	// ========================================

	// Operation launched into the execute pipeline
	// Rt is zero when the instruction writes no register
	typedef struct packed {
		logic        valid;
		opcode_t     op;
		regspec_t    Rt;
		logic [31:0] a;
		logic [31:0] b;
	} exec_op_t;

	// Result returned to the register file and the scoreboard
	typedef struct packed {
		logic        v;
		regspec_t    Rt;
		logic [31:0] data;
	} writeback_t;

endpackage

/* design/reg_file.sv */
`timescale 1ns/1ps

module reg_file
	import isa_pkg::*, pipe_pkg::*;
(
	input  logic        clk,
	input  logic        rst,
	input  regspec_t    ra,
	input  regspec_t    rb,
	output logic [31:0] rd_a,
	output logic [31:0] rd_b,
	input  writeback_t  wb
);

	logic [31:0] regs [NUM_REGS];

	// Single write port fed straight from the writeback bus
	// r0 is never written
	always_ff @(posedge clk or posedge rst)
	begin
		if (rst)
		begin
			for (int i = 0; i < NUM_REGS; i++)
				regs[i] <= '0;
		end
		else if (wb.v && (wb.Rt != '0))
			regs[wb.Rt] <= wb.data;
	end

	// Asynchronous read ports, r0 reads as zero
	assign rd_a = (ra == '0) ? 32'h0 : regs[ra];
	assign rd_b = (rb == '0) ? 32'h0 : regs[rb];

endmodule

/* design/reg_scoreboard.sv */
`timescale 1ns/1ps

module reg_scoreboard
	import isa_pkg::*, pipe_pkg::*;
(
	input  logic        clk,
	input  logic        rst,
	input  decode_bus_t db,
	input  writeback_t  wb,
	input  logic        will_issue,
	output logic        can_issue
);

	regs_bitmap_t busy;
	regs_bitmap_t nxt_busy;
	regs_bitmap_t srcs;
	regs_bitmap_t tgts;
	regs_bitmap_t clr_bm;
	regs_bitmap_t set_bm;
	regs_bitmap_t hazard;

	// ========================================
	// Register bitmaps of the head instruction
	// ========================================

	// Registers the instruction reads
	always_comb
	begin
		srcs = '0;
		if (db.v)
		begin
			if (db.hasRa)
				srcs[db.Ra] = 1'b1;
			if (db.hasRb)
				srcs[db.Rb] = 1'b1;
		end
	end

	// Register the instruction writes
	always_comb
	begin
		tgts = '0;
		if (db.v && db.hasRt && db.rfwr)
			tgts[db.Rt] = 1'b1;
	end

	// ========================================
	// Busy bits
	// ========================================

	// A writeback releases its register
	always_comb
	begin
		clr_bm = '0;
		if (wb.v)
			clr_bm[wb.Rt] = 1'b1;
	end

	// Bit zero is masked so r0 is never marked busy
	assign set_bm   = tgts & {{(NUM_REGS-1){will_issue}}, 1'b0};
	assign nxt_busy = (busy & ~clr_bm) | set_bm;

	always_ff @(posedge clk or posedge rst)
	begin
		if (rst)
			busy <= '0;
		else
			busy <= nxt_busy;
	end

	// A busy target blocks too, which keeps writebacks to one register in order
	assign hazard    = (srcs | tgts) & busy;
	assign can_issue = (hazard[NUM_REGS-1:1] == '0);

endmodule

/* issue_stage.f */
design/isa_pkg.sv
design/pipe_pkg.sv
design/instr_queue.sv
design/instr_decode.sv
design/reg_scoreboard.sv
design/reg_file.sv
design/exec_pipe.sv
design/issue_ctrl.sv
design/issue_stage.sv
tests/issue_stage_chk.sv
tests/issue_stage_tb.sv

/* tests/issue_patterns.txt */
// Columns: instruction word, expected Rt (00 when no writeback), expected value
// Word layout: opcode[31:28] Rt[27:22] Ra[21:16] then Rb[15:10] or imm[15:0]
5040FFFB 01 FFFFFFFB
60808001 02 00008001
50C01234 03 00001234
11010800 04 00007FFC
21430400 05 00001239
31810C00 06 00001230
41C41400 07 00006DC5
52070001 08 00006DC6
12482000 09 0000DB8C
22890400 0A 0000DB91
428A0800 0A 00005B90
62CAF000 0B 0000FB90
500B0007 00 00000000
00000000 00 00000000
13002C00 0C 0000FB90
F0000000 00 00000000
55000100 14 00000100
55407FFF 15 00007FFF
6580FFFF 16 0000FFFF
15D45400 17 000080FF
26005800 18 FFFF0001
36585C00 19 00000001
4FD93000 3F 0000FB91
56BFFFFF 1A 0000FB90
101A6800 00 00000000
16C00000 1B 00000000

/* tests/issue_stage_chk.sv */
`timescale 1ns/1ps

module issue_stage_chk
	import isa_pkg::*, pipe_pkg::*;
(
	input logic       clk,
	input logic       rst,
	input logic       in_valid,
	input logic       pop,
	input logic       credit_return,
	input writeback_t wb
);

	// Shadow of the queue occupancy, rebuilt from pushes and pops
	credit_t occ;

	always_ff @(posedge clk or posedge rst)
	begin
		if (rst)
			occ <= '0;
		else
			occ <= occ + in_valid - pop;
	end

	// ========================================
	// Protocol checks
	// ========================================

	// A push into a full queue means the sender ignored its credits
	assert property (@(posedge clk) disable iff (rst) in_valid |-> (occ < QUEUE_DEPTH))
		else $error("push into a full instruction queue");

	// Writebacks to r0 must be squashed before the bus
	assert property (@(posedge clk) disable iff (rst) wb.v |-> (wb.Rt != '0))
		else $error("writeback with target r0");

	// Every pop hands back one credit on the next cycle
	assert property (@(posedge clk) disable iff (rst) pop |=> credit_return)
		else $error("credit not returned after a pop");

endmodule

bind issue_stage issue_stage_chk u_chk (
	.clk           (clk),
	.rst           (rst),
	.in_valid      (in_valid),
	.pop           (pop),
	.credit_return (credit_return),
	.wb            (wb)
);

/* tests/issue_stage_tb.sv */
`timescale 1ns/1ps

module issue_stage_tb
	import isa_pkg::*, pipe_pkg::*;
();

	// Upper bound on the number of rows in the pattern file
	localparam int MAX_PATTERNS = 64;
	// Cycles allowed for the pipeline to drain after the last send
	localparam int DRAIN_LIMIT = 200;

	logic       clk;
	logic       rst;
	logic       in_valid;
	instr_t     in_instr;
	logic       credit_return;
	writeback_t wb;

	// Three words per row: instruction, expected Rt, expected value
	logic [31:0] pat_mem [3*MAX_PATTERNS];
	int          num_pat;
	bit          loaded;

	// Writebacks still owed by the DUT, oldest first
	writeback_t  exp_q [$];

	int          sent_cnt;
	int          returned_cnt;
	int          mismatch_errs;
	int          other_errs;
	int unsigned lcg_state;

	issue_stage dut (
		.clk           (clk),
		.rst           (rst),
		.in_valid      (in_valid),
		.in_instr      (in_instr),
		.credit_return (credit_return),
		.wb            (wb)
	);

	// 40 ns clock period
	initial clk = 1'b0;
	always #20 clk = ~clk;

	// ========================================
	// Helpers
	// ========================================

	// Linear congruential generator, the top bits are the best mixed
	function automatic int unsigned next_rand();
		lcg_state = lcg_state * 32'd1103515245 + 32'd12345;
		return lcg_state >> 16;
	endfunction

	// Credits the sender holds right now
	function automatic int credits_held();
		return QUEUE_DEPTH - sent_cnt + returned_cnt;
	endfunction

	// Unused slots carry an Rt above 63, which marks the end of the table
	task automatic load_patterns();
		writeback_t exp_wb;
		for (int k = 0; k < 3*MAX_PATTERNS; k++)
			pat_mem[k] = 32'hffff_ffff;
		$readmemh("tests/issue_patterns.txt", pat_mem);
		num_pat = 0;
		while (num_pat < MAX_PATTERNS && pat_mem[3*num_pat+1] < NUM_REGS)
		begin
			// Rows with Rt of zero leave nothing on the writeback bus
			if (pat_mem[3*num_pat+1] != 0)
			begin
				exp_wb.v    = 1'b1;
				exp_wb.Rt   = pat_mem[3*num_pat+1][5:0];
				exp_wb.data = pat_mem[3*num_pat+2];
				exp_q.push_back(exp_wb);
			end
			num_pat++;
		end
	endtask

	// ========================================
	// Credit tracking and writeback monitor
	// ========================================

	// Sampled mid cycle where the registered outputs are settled
	always @(negedge clk)
	begin
		if (!rst && credit_return)
			returned_cnt++;
	end

	always @(negedge clk)
	begin
		writeback_t exp_wb;
		if (!rst && wb.v)
		begin
			if (exp_q.size() == 0)
			begin
				$display("unexpected extra writeback to r%0d at %0t", wb.Rt, $time);
				other_errs++;
			end
			else
			begin
				exp_wb = exp_q.pop_front();
				if (wb.Rt != exp_wb.Rt || wb.data != exp_wb.data)
				begin
					$display("mismatch at %0t: expected r%0d = %08h, got r%0d = %08h",
						$time, exp_wb.Rt, exp_wb.data, wb.Rt, wb.data);
					mismatch_errs++;
				end
			end
		end
	end

	// ========================================
	// Stimulus
	// ========================================

	initial
	begin
		int gap;
		int drain;
		rst           = 1'b1;
		in_valid      = 1'b0;
		in_instr      = '0;
		sent_cnt      = 0;
		returned_cnt  = 0;
		mismatch_errs = 0;
		other_errs    = 0;
		lcg_state     = 62;
		load_patterns();
		loaded = 1'b1;
		if (num_pat == 0)
		begin
			$display("no patterns were read from the pattern file");
			other_errs++;
		end

		repeat (8) @(posedge clk);
		#2 rst = 1'b0;

		for (int i = 0; i < num_pat; i++)
		begin
			// Random gaps first, then back to back bursts that fill the queue
			gap = (i < num_pat/2) ? int'(next_rand() % 4) : 0;
			if (gap > 0)
				in_valid = 1'b0;
			repeat (gap)
			begin
				@(posedge clk);
				#2;
			end
			while (credits_held() <= 0)
			begin
				in_valid = 1'b0;
				@(posedge clk);
				#2;
			end
			in_valid = 1'b1;
			in_instr = pat_mem[3*i];
			sent_cnt++;
			@(posedge clk);
			#2;
		end
		in_valid = 1'b0;

		// Wait for every writeback and every credit to come home
		drain = 0;
		while (drain < DRAIN_LIMIT && (exp_q.size() != 0 || credits_held() != QUEUE_DEPTH))
		begin
			@(posedge clk);
			drain++;
		end
		// A few more cycles to catch stray writebacks
		repeat (EXEC_STAGES + 4) @(posedge clk);

		if (exp_q.size() != 0)
		begin
			$display("%0d expected writebacks never arrived", exp_q.size());
			other_errs++;
		end
		if (credits_held() != QUEUE_DEPTH)
		begin
			$display("credits not restored after draining: holding %0d of %0d",
				credits_held(), QUEUE_DEPTH);
			other_errs++;
		end

		$display("errors: %0d mismatches, %0d other failures", mismatch_errs, other_errs);
		if (mismatch_errs == 0 && other_errs == 0)
			$display(">>> PASS");
		else
			$display(">>> FAIL");
		$finish;
	end

	// Watchdog scaled to the length of the pattern table
	initial
	begin
		wait (loaded);
		repeat (num_pat * 30 + 200) @(posedge clk);
		$display("timeout: the run did not finish within %0d cycles", num_pat * 30 + 200);
		$display("errors: %0d mismatches, %0d other failures", mismatch_errs, other_errs + 1);
		$display(">>> FAIL");
		$finish;
	end

endmodule
